// File: Makefile
TOP := tb_uart

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_uart.sv
`timescale 1ns/10ps

module tb_uart;

  localparam int N_LOOP = 16;
  // one frame plus one idle bit, in clock cycles, at divisors 14 and 27
  localparam int FRAME7 = 12 * 16 * 14;
  localparam int FRAME6 = 12 * 16 * 27;
  // 30 frames at the fast rate, 4 at the slower one with credit gaps, doubled
  localparam int LIMIT = 2 * (30 * FRAME7 + 4 * (FRAME6 + 15 * 64)) + 2000;

  logic                   Rx_VALID;
  logic                   reset;
  logic [2:0]             baud_select;
  logic                   tx_en;
  logic                   rx_en;
  logic                   tx_wr;
  uart_pkg::uart_word_t   tx_data;
  logic                   tx_credit;
  logic                   tx_busy;
  logic                   txd;
  logic                   rxd;
  logic                   rx_credit;
  uart_pkg::uart_rx_out_t rx_out;
  // serial line source select
  logic                   loopback;
  logic                   rxd_model;

  int errors = 0;
  int checks = 0;
  // host bookkeeping for both credit loops
  int written = 0;
  int returned = 0;
  int granted = 0;
  int delivered = 0;
  // a pop was seen last cycle, busy must be up now
  logic busy_due = 1'b0;
  logic [31:0] lfsr_state;
  uart_pkg::uart_rx_word_t exp_q[$];
  uart_pkg::uart_rx_word_t exp_word;

  assign rxd = loopback ? txd : rxd_model;

  uart_top dut (
    .Rx_VALID    (Rx_VALID),
    .reset       (reset),
    .baud_select (baud_select),
    .tx_en       (tx_en),
    .rx_en       (rx_en),
    .tx_wr       (tx_wr),
    .tx_data     (tx_data),
    .tx_credit   (tx_credit),
    .tx_busy     (tx_busy),
    .txd         (txd),
    .rxd         (rxd),
    .rx_credit   (rx_credit),
    .rx_out      (rx_out)
  );

  always #20 Rx_VALID = ~Rx_VALID;

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  // clock cycles per serial bit, 16 ticks of the selected divisor
  function automatic int cycles_per_bit(input logic [2:0] sel);
    case (sel)
      3'd0:    return 16 * 5208;
      3'd1:    return 16 * 1302;
      3'd2:    return 16 * 326;
      3'd3:    return 16 * 163;
      3'd4:    return 16 * 81;
      3'd5:    return 16 * 41;
      3'd6:    return 16 * 27;
      default: return 16 * 14;
    endcase
  endfunction

  // expected receive word from the bits on the line
  // even parity: data bits plus parity bit xor to zero
  function automatic uart_pkg::uart_rx_word_t expected_word(input logic [7:0] data,
      input logic par_bit, input logic stop_bit, input logic lost_before);
    uart_pkg::uart_rx_word_t w;
    w.data    = data;
    w.perror  = par_bit ^ (^data);
    w.ferror  = !stop_bit;
    w.overrun = lost_before;
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic flag_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // host write, only with a free tx credit
  task automatic write_byte(input logic [7:0] b);
    @(negedge Rx_VALID);
    while (written - returned >= uart_pkg::TX_DEPTH) begin
      @(negedge Rx_VALID);
    end
    tx_wr   = 1'b1;
    tx_data = b;
    written++;
    exp_q.push_back(expected_word(b, ^b, 1'b1, 1'b0));
    @(negedge Rx_VALID);
    tx_wr = 1'b0;
  endtask

  // back-to-back credit pulses, one per cycle
  task automatic grant_credits(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge Rx_VALID);
      rx_credit = 1'b1;
      granted++;
    end
    @(negedge Rx_VALID);
    rx_credit = 1'b0;
  endtask

  // start, 8 data lsb first, parity, stop, then one idle bit
  task automatic send_frame(input logic [7:0] b, input logic flip_par, input logic stop_low);
    logic [11:0] bits;
    int nb;
    nb = cycles_per_bit(baud_select);
    bits = {1'b1, !stop_low, (^b) ^ flip_par, b, 1'b0};
    for (int i = 0; i < 12; i++) begin
      @(negedge Rx_VALID);
      rxd_model = bits[i];
      repeat (nb - 1) @(negedge Rx_VALID);
    end
  endtask

  // tx credit returns, never more than written
  // idle transmitter at the pop, busy one cycle later
  always @(negedge Rx_VALID) begin
    if (busy_due) begin
      check_value("tx_busy", tx_busy, 1'b1);
    end
    busy_due = 1'b0;
    if (!reset && tx_credit) begin
      check_value("tx_busy", tx_busy, 1'b0);
      busy_due = 1'b1;
      returned++;
      if (returned > written) begin
        flag_failure("a tx credit came back for a byte that was never written");
      end
    end
  end

  // compare each delivery against the next expected word
  always @(negedge Rx_VALID) begin
    if (!reset && rx_out.valid) begin
      delivered++;
      if (delivered > granted) begin
        flag_failure("a word was delivered without a receive credit");
      end
      if (exp_q.size() == 0) begin
        flag_failure("a word was delivered that no test expected");
      end else begin
        exp_word = exp_q.pop_front();
        check_value("rx_out.word", 32'(rx_out.word), 32'(exp_word));
      end
    end
  end

  initial begin : watchdog
    repeat (LIMIT) @(posedge Rx_VALID);
    flag_failure("timeout: the tests did not complete in the expected time");
    finish_run();
  end

  initial begin : stimulus
    int base;
    logic [7:0] b;
    Rx_VALID    = 1'b0;
    reset       = 1'b1;
    baud_select = 3'd7;
    tx_en       = 1'b1;
    rx_en       = 1'b1;
    tx_wr       = 1'b0;
    tx_data     = '0;
    rx_credit   = 1'b0;
    loopback    = 1'b1;
    rxd_model   = 1'b1;
    lfsr_state  = 32'hc9ab_80d9;
    repeat (4) @(negedge Rx_VALID);
    reset = 1'b0;

    // loopback, one credit ahead of each word
    base = delivered;
    fork
      begin
        for (int i = 0; i < N_LOOP; i++) begin
          write_byte(8'(rand_bits(8)));
        end
      end
      begin
        for (int i = 0; i < N_LOOP; i++) begin
          grant_credits(1);
          wait (delivered >= base + i + 1);
        end
      end
    join
    check_value("tx_credit count", returned, written);
    wait (!tx_busy);

    // parity and stop faults from the line model
    @(negedge Rx_VALID);
    loopback = 1'b0;
    base = delivered;
    b = 8'(rand_bits(8));
    exp_q.push_back(expected_word(b, (^b) ^ 1'b1, 1'b1, 1'b0));
    send_frame(b, 1'b1, 1'b0);
    b = 8'(rand_bits(8));
    exp_q.push_back(expected_word(b, ^b, 1'b0, 1'b0));
    send_frame(b, 1'b0, 1'b1);
    grant_credits(2);
    wait (delivered >= base + 2);

    // words wait in the queue until credits arrive
    base = delivered;
    repeat (3) begin
      b = 8'(rand_bits(8));
      exp_q.push_back(expected_word(b, ^b, 1'b1, 1'b0));
      send_frame(b, 1'b0, 1'b0);
    end
    check_value("words without credit", delivered, base);
    grant_credits(2);
    wait (delivered >= base + 2);
    repeat (32) @(negedge Rx_VALID);
    check_value("words for two credits", delivered, base + 2);
    grant_credits(1);
    wait (delivered >= base + 3);

    // two frames beyond a full queue are lost
    base = delivered;
    for (int i = 0; i < uart_pkg::RX_DEPTH + 2; i++) begin
      b = 8'(rand_bits(8));
      if (i < uart_pkg::RX_DEPTH) begin
        exp_q.push_back(expected_word(b, ^b, 1'b1, 1'b0));
      end
      send_frame(b, 1'b0, 1'b0);
    end
    grant_credits(uart_pkg::RX_DEPTH);
    wait (delivered >= base + uart_pkg::RX_DEPTH);
    b = 8'(rand_bits(8));
    exp_q.push_back(expected_word(b, ^b, 1'b1, 1'b1));
    send_frame(b, 1'b0, 1'b0);
    grant_credits(1);
    wait (delivered >= base + uart_pkg::RX_DEPTH + 1);

    // receiver off, credit waiting but nothing arrives
    base = delivered;
    grant_credits(1);
    @(negedge Rx_VALID);
    rx_en = 1'b0;
    send_frame(8'(rand_bits(8)), 1'b0, 1'b0);
    check_value("words while disabled", delivered, base);
    @(negedge Rx_VALID);
    rx_en = 1'b1;
    b = 8'(rand_bits(8));
    exp_q.push_back(expected_word(b, ^b, 1'b1, 1'b0));
    send_frame(b, 1'b0, 1'b0);
    wait (delivered >= base + 1);

    // slower rate, random gaps before each credit
    @(negedge Rx_VALID);
    baud_select = 3'd6;
    loopback    = 1'b1;
    base = delivered;
    for (int i = 0; i < 4; i++) begin
      write_byte(8'(rand_bits(8)));
    end
    for (int i = 0; i < 4; i++) begin
      repeat (rand_bits(4) * 64) @(negedge Rx_VALID);
      grant_credits(1);
      wait (delivered >= base + i + 1);
    end
    // last stop bit ends about half a bit after its mid sample
    repeat (cycles_per_bit(3'd6)) @(negedge Rx_VALID);
    check_value("tx_busy", tx_busy, 1'b0);
    check_value("tx_credit count", returned, written);
    finish_run();
  end

endmodule

// File: dv/uart_sva.sv
`timescale 1ns/10ps

module uart_fifo_sva #(
  parameter int DEPTH        = 4,
  parameter bit CREDIT_GATED = 1'b0
) (
  input logic                          Rx_VALID,
  input logic                          reset,
  input logic                          push,
  input logic                          full,
  input logic                          pop_valid,
  input logic                          credit_in,
  input logic                          take,
  input logic [$clog2(DEPTH+1)-1:0]    count,
  input logic [uart_pkg::CREDIT_W-1:0] credits
);

  // producer must respect full
  a_no_push_full: assert property (@(posedge Rx_VALID) disable iff (reset)
    push |-> !full) else $error("push while queue full");

  // last word out leaves the queue empty, nothing valid after it
  a_pop_has_word: assert property (@(posedge Rx_VALID) disable iff (reset)
    (take && count == 1 && !push) |=> !pop_valid)
    else $error("pop_valid with empty queue");

  // and in credit mode the last credit spent stops delivery
  a_pop_has_credit: assert property (@(posedge Rx_VALID) disable iff (reset)
    (CREDIT_GATED && take && credits == 1 && !credit_in) |=> !pop_valid)
    else $error("pop_valid with no credit");

  a_count_bound: assert property (@(posedge Rx_VALID) disable iff (reset)
    count <= DEPTH) else $error("queue count above depth");

  // credit counter must not wrap past its maximum
  a_credit_no_overflow: assert property (@(posedge Rx_VALID) disable iff (reset)
    (CREDIT_GATED && credit_in && !take) |-> credits != '1) else $error("credit overflow");

endmodule

// one checker per queue instance, both payloads
bind uart_credit_fifo uart_fifo_sva #(
  .DEPTH        (DEPTH),
  .CREDIT_GATED (CREDIT_GATED)
) u_fifo_sva (
  .Rx_VALID  (Rx_VALID),
  .reset     (reset),
  .push      (push),
  .full      (full),
  .pop_valid (pop_valid),
  .credit_in (credit_in),
  .take      (take),
  .count     (count),
  .credits   (credits)
);

// File: flist.f
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_credit_fifo.sv
logic/uart_transmitter.sv
logic/uart_receiver.sv
logic/uart_top.sv
dv/uart_sva.sv
dv/tb_uart.sv

// File: logic/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen (
  input  logic       Rx_VALID,
  input  logic       reset,
  input  logic [2:0] baud_select,
  output logic       tick
);

  // cycles left until the next tick
  logic [uart_pkg::DIV_W-1:0] cnt;
  logic [uart_pkg::DIV_W-1:0] reload;

  // divisor for the selected rate, minus one
  // counting down to zero gives one tick per divisor cycles
  assign reload = uart_pkg::DIVISOR_TABLE[baud_select] - 1'b1;

  always_ff @(posedge Rx_VALID) begin
    if (reset) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == '0) begin
      // baud_select is only looked at here
      // so a rate change waits for the current period to end
      cnt  <= reload;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// File: logic/uart_credit_fifo.sv
`timescale 1ns/10ps

module uart_credit_fifo #(
  parameter type T            = uart_pkg::uart_word_t,
  parameter int  DEPTH        = 4,
  parameter bit  CREDIT_GATED = 1'b0
) (
  input  logic Rx_VALID,
  input  logic reset,
  input  logic push,
  input  T     push_data,
  output logic full,
  input  logic credit_in,
  output logic pop_valid,
  output T     pop_data,
  input  logic pop
);

  // storage, no reset needed on payload
  T mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic [uart_pkg::CREDIT_W-1:0] credits;
  logic credit_ok;
  logic do_push;
  logic take;

  assign full     = (count == DEPTH);
  assign pop_data = mem[rd_ptr];
  assign do_push  = push && !full;

  // word leaves only when present and allowed
  assign pop_valid = (count != '0) && credit_ok;

  // credit mode delivers on its own, pop mode waits for the consumer
  assign take = CREDIT_GATED ? pop_valid : (pop && pop_valid);

  generate
    if (CREDIT_GATED) begin : g_credit
      // one credit per credit_in pulse, one spent per delivery
      always_ff @(posedge Rx_VALID) begin
        if (reset) begin
          credits <= '0;
        end else begin
          case ({credit_in, take})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
          endcase
        end
      end
      assign credit_ok = (credits != '0);
    end else begin : g_pop
      // consumer handshake only
      assign credits   = '0;
      assign credit_ok = 1'b1;
    end
  endgenerate

  always_ff @(posedge Rx_VALID) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge Rx_VALID) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: logic/uart_pkg.sv
package uart_pkg;

  // frame shape
  // one start bit, eight data bits lsb first, even parity, one stop bit
  localparam int OVERSAMPLE = 16;
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;

  // widths of the per-bit tick counter and the data bit index
  localparam int TICK_W = $clog2(OVERSAMPLE);
  localparam int BIT_W  = $clog2(DATA_BITS);

  // tick at which the receiver checks the start bit
  // about half a bit after the falling edge
  localparam int MID_TICK = OVERSAMPLE / 2 - 1;

  // clock cycles per oversample tick, 25 MHz clock
  // index is baud_select, 300 baud at 0 up to 115200 baud at 7
  localparam int DIV_W = 13;
  localparam logic [7:0][DIV_W-1:0] DIVISOR_TABLE = {
    13'd14,    // 115200
    13'd27,    // 57600
    13'd41,    // 38400
    13'd81,    // 19200
    13'd163,   // 9600
    13'd326,   // 4800
    13'd1302,  // 1200
    13'd5208   // 300
  };

  // host queue depths and credit counter width
  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 4;
  localparam int CREDIT_W = 3;

  // transmit queue payload
  typedef logic [DATA_BITS-1:0] uart_word_t;

  // one received frame with its status flags
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 perror;
    logic                 ferror;
    logic                 overrun;
  } uart_rx_word_t;

  // word as seen by the host, valid for one cycle per delivery
  typedef struct packed {
    logic          valid;
    uart_rx_word_t word;
  } uart_rx_out_t;

  // frame phases, shared by both serial engines
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } uart_state_e;

endpackage

// File: logic/uart_receiver.sv
`timescale 1ns/10ps

module uart_receiver (
  input  logic                    Rx_VALID,
  input  logic                    reset,
  input  logic                    tick,
  input  logic                    rx_en,
  input  logic                    rxd,
  input  logic                    full,
  output logic                    push,
  output uart_pkg::uart_rx_word_t push_data
);

  uart_pkg::uart_state_e state;

  // two-flop synchronizer plus one more stage for edge detect
  logic rxd_meta;
  logic rxd_sync;
  logic rxd_prev;

  logic [uart_pkg::TICK_W-1:0] tick_cnt;
  logic [uart_pkg::BIT_W-1:0]  bit_idx;
  uart_pkg::uart_word_t        shreg;
  logic                        parity;
  logic                        perror;
  // a frame was lost since the last stored word
  logic                        overrun_flag;
  logic                        mid_start;
  logic                        mid_bit;
  logic                        frame_ok;

  // start bit checked about half a bit in
  assign mid_start = tick && (tick_cnt == uart_pkg::TICK_W'(uart_pkg::MID_TICK));
  // later bits one full bit apart from there
  assign mid_bit   = tick && (tick_cnt == uart_pkg::TICK_W'(uart_pkg::OVERSAMPLE - 1));

  // queue has room for the finished frame
  assign frame_ok = !full;

  always_ff @(posedge Rx_VALID) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge Rx_VALID) begin
    if (reset) begin
      state        <= uart_pkg::ST_IDLE;
      tick_cnt     <= '0;
      bit_idx      <= '0;
      parity       <= 1'b0;
      perror       <= 1'b0;
      overrun_flag <= 1'b0;
      push         <= 1'b0;
    end else begin
      push <= 1'b0;
      if (state != uart_pkg::ST_IDLE && tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      if (!rx_en) begin
        // disabled, drop any partial frame
        state <= uart_pkg::ST_IDLE;
      end else begin
        case (state)
          uart_pkg::ST_IDLE: begin
            // falling edge on the line
            if (rxd_prev && !rxd_sync) begin
              state    <= uart_pkg::ST_START;
              tick_cnt <= '0;
            end
          end
          uart_pkg::ST_START: begin
            if (mid_start) begin
              tick_cnt <= '0;
              bit_idx  <= '0;
              parity   <= 1'b0;
              // glitch if the line is high again
              state <= rxd_sync ? uart_pkg::ST_IDLE : uart_pkg::ST_DATA;
            end
          end
          uart_pkg::ST_DATA: begin
            if (mid_bit) begin
              parity <= parity ^ rxd_sync;
              if (bit_idx == uart_pkg::BIT_W'(uart_pkg::DATA_BITS - 1)) begin
                state <= uart_pkg::ST_PARITY;
              end else begin
                bit_idx <= bit_idx + 1'b1;
              end
            end
          end
          uart_pkg::ST_PARITY: begin
            if (mid_bit) begin
              // even parity, received bit must match xor of data
              perror <= parity ^ rxd_sync;
              state  <= uart_pkg::ST_STOP;
            end
          end
          uart_pkg::ST_STOP: begin
            if (mid_bit) begin
              state <= uart_pkg::ST_IDLE;
              if (frame_ok) begin
                push         <= 1'b1;
                overrun_flag <= 1'b0;
              end else begin
                // frame is lost, next stored word reports it
                overrun_flag <= 1'b1;
              end
            end
          end
          default: state <= uart_pkg::ST_IDLE;
        endcase
      end
    end
  end

  // data shifts in from the top, lsb arrives first
  always_ff @(posedge Rx_VALID) begin
    if (state == uart_pkg::ST_DATA && mid_bit) begin
      shreg <= {rxd_sync, shreg[uart_pkg::DATA_BITS-1:1]};
    end
  end

  // result word, captured at mid stop bit
  always_ff @(posedge Rx_VALID) begin
    if (state == uart_pkg::ST_STOP && mid_bit) begin
      push_data.data    <= shreg;
      push_data.perror  <= perror;
      push_data.ferror  <= !rxd_sync;
      push_data.overrun <= overrun_flag;
    end
  end

endmodule

// File: logic/uart_top.sv
`timescale 1ns/10ps

module uart_top (
  input  logic                   Rx_VALID,
  input  logic                   reset,
  input  logic [2:0]             baud_select,
  input  logic                   tx_en,
  input  logic                   rx_en,
  input  logic                   tx_wr,
  input  uart_pkg::uart_word_t   tx_data,
  output logic                   tx_credit,
  output logic                   tx_busy,
  output logic                   txd,
  input  logic                   rxd,
  input  logic                   rx_credit,
  output uart_pkg::uart_rx_out_t rx_out
);

  logic                    tick;
  // transmit side
  logic                    tx_word_valid;
  uart_pkg::uart_word_t    tx_word;
  logic                    tx_pop;
  // receive side
  logic                    rx_full;
  logic                    rx_push;
  uart_pkg::uart_rx_word_t rx_push_data;
  logic                    rx_pop_valid;
  uart_pkg::uart_rx_word_t rx_pop_data;

  // every word taken by the transmitter frees one host credit
  assign tx_credit = tx_pop;

  // host sees the delivery strobe and the word together
  assign rx_out.valid = rx_pop_valid;
  assign rx_out.word  = rx_pop_data;

  // one tick source for both directions
  uart_baud_gen u_baud_gen (
    .Rx_VALID    (Rx_VALID),
    .reset       (reset),
    .baud_select (baud_select),
    .tick        (tick)
  );

  // host credits keep this queue from filling, so full is not needed
  uart_credit_fifo #(
    .T            (uart_pkg::uart_word_t),
    .DEPTH        (uart_pkg::TX_DEPTH),
    .CREDIT_GATED (1'b0)
  ) u_tx_fifo (
    .Rx_VALID  (Rx_VALID),
    .reset     (reset),
    .push      (tx_wr),
    .push_data (tx_data),
    .full      (),
    .credit_in (1'b0),
    .pop_valid (tx_word_valid),
    .pop_data  (tx_word),
    .pop       (tx_pop)
  );

  uart_transmitter u_transmitter (
    .Rx_VALID   (Rx_VALID),
    .reset      (reset),
    .tick       (tick),
    .tx_en      (tx_en),
    .word_valid (tx_word_valid),
    .word       (tx_word),
    .pop        (tx_pop),
    .txd        (txd),
    .tx_busy    (tx_busy)
  );

  uart_receiver u_receiver (
    .Rx_VALID  (Rx_VALID),
    .reset     (reset),
    .tick      (tick),
    .rx_en     (rx_en),
    .rxd       (rxd),
    .full      (rx_full),
    .push      (rx_push),
    .push_data (rx_push_data)
  );

  // delivery paced by host credits, no pop handshake
  uart_credit_fifo #(
    .T            (uart_pkg::uart_rx_word_t),
    .DEPTH        (uart_pkg::RX_DEPTH),
    .CREDIT_GATED (1'b1)
  ) u_rx_fifo (
    .Rx_VALID  (Rx_VALID),
    .reset     (reset),
    .push      (rx_push),
    .push_data (rx_push_data),
    .full      (rx_full),
    .credit_in (rx_credit),
    .pop_valid (rx_pop_valid),
    .pop_data  (rx_pop_data),
    .pop       (1'b0)
  );

endmodule

// File: logic/uart_transmitter.sv
`timescale 1ns/10ps

module uart_transmitter (
  input  logic                 Rx_VALID,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 tx_en,
  input  logic                 word_valid,
  input  uart_pkg::uart_word_t word,
  output logic                 pop,
  output logic                 txd,
  output logic                 tx_busy
);

  uart_pkg::uart_state_e state;

  logic [uart_pkg::TICK_W-1:0] tick_cnt;
  logic [uart_pkg::BIT_W-1:0]  bit_idx;
  // data being shifted out, lsb first
  uart_pkg::uart_word_t        shreg;
  // running xor of the bits already sent
  logic                        parity;
  logic                        bit_done;

  // take a word on a tick while idle and enabled
  assign pop = (state == uart_pkg::ST_IDLE) && tick && tx_en && word_valid;

  // last tick of the current bit
  assign bit_done = tick && (tick_cnt == uart_pkg::TICK_W'(uart_pkg::OVERSAMPLE - 1));

  always_ff @(posedge Rx_VALID) begin
    if (reset) begin
      state    <= uart_pkg::ST_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      parity   <= 1'b0;
      txd      <= 1'b1;
      tx_busy  <= 1'b0;
    end else begin
      // count ticks inside a bit
      if (state != uart_pkg::ST_IDLE && tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      case (state)
        uart_pkg::ST_IDLE: begin
          if (pop) begin
            // start bit goes out right away
            state    <= uart_pkg::ST_START;
            tick_cnt <= '0;
            bit_idx  <= '0;
            parity   <= 1'b0;
            txd      <= 1'b0;
            tx_busy  <= 1'b1;
          end
        end
        uart_pkg::ST_START: begin
          if (bit_done) begin
            state <= uart_pkg::ST_DATA;
            txd   <= shreg[0];
          end
        end
        uart_pkg::ST_DATA: begin
          if (bit_done) begin
            parity <= parity ^ shreg[0];
            if (bit_idx == uart_pkg::BIT_W'(uart_pkg::DATA_BITS - 1)) begin
              // even parity, bit equals xor of all data bits
              state <= uart_pkg::ST_PARITY;
              txd   <= parity ^ shreg[0];
            end else begin
              bit_idx <= bit_idx + 1'b1;
              txd     <= shreg[1];
            end
          end
        end
        uart_pkg::ST_PARITY: begin
          if (bit_done) begin
            state <= uart_pkg::ST_STOP;
            txd   <= 1'b1;
          end
        end
        uart_pkg::ST_STOP: begin
          // frame ends here even if tx_en dropped meanwhile
          if (bit_done) begin
            state   <= uart_pkg::ST_IDLE;
            tx_busy <= 1'b0;
          end
        end
        default: state <= uart_pkg::ST_IDLE;
      endcase
    end
  end

  // payload shifter
  always_ff @(posedge Rx_VALID) begin
    if (pop) begin
      shreg <= word;
    end else if (state == uart_pkg::ST_DATA && bit_done) begin
      shreg <= shreg >> 1;
    end
  end

endmodule
